//--- bench/csr_assertions.sv
`timescale 1ns/1ps

module csr_assertions (
  input logic           clk,
  input logic           rst_n,
  input logic           stall_i,
  input logic           trap_valid_i,
  input csr_pkg::crmd_t crmd_i,
  input logic [31:0]    rd_data_i,
  input logic           int_pending_i
);

  // no pending interrupt coming out of reset
  reset_irq_low: assert property (@(posedge clk) !rst_n |=> !int_pending_i)
    else $error("int_pending_o high right after reset");

  trap_clears_mode: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_i |=> (crmd_i.plv == 2'd0 && !crmd_i.ie))
    else $error("CRMD plv or ie not cleared after a trap");

  stall_holds_read: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |=> $stable(rd_data_i))
    else $error("read data changed during a stall");

endmodule

bind csr_top csr_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .stall_i       (stall_i),
  .trap_valid_i  (trap.valid),
  .crmd_i        (csr_view.crmd),
  .rd_data_i     (rd_data_o),
  .int_pending_i (int_pending_o)
);

//--- bench/csr_tb.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_tb;

  import csr_pkg::*;

  logic                   clk;
  logic                   rst_n;
  csr_wr_t                wr;
  logic [`CSR_ADDR_W-1:0] rd_addr;
  logic [1:0]             rdcnt;
  logic                   stall;
  excp_t                  excp;
  logic [`CSR_DATA_W-1:0] pc;
  logic [`CSR_DATA_W-1:0] vaddr;
  logic                   ertn;
  logic [`HW_IRQ_W-1:0]   hw_int;
  logic [`CSR_DATA_W-1:0] rd_data;
  logic                   int_pending;
  logic [`CSR_DATA_W-1:0] era;
  logic [`CSR_DATA_W-1:0] eentry;

  // one entry per test record
  string       name_q[$];
  string       op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] mask_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] last_cnt;
  int          n_rec;
  logic        loaded;

  csr_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_i          (wr),
    .rd_addr_i     (rd_addr),
    .rdcnt_i       (rdcnt),
    .stall_i       (stall),
    .excp_i        (excp),
    .pc_i          (pc),
    .vaddr_i       (vaddr),
    .ertn_i        (ertn),
    .hw_int_i      (hw_int),
    .rd_data_o     (rd_data),
    .int_pending_o (int_pending),
    .era_o         (era),
    .eentry_o      (eentry)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %08h actual %08h", name, expected, actual);
      abort_run("stopping at the first mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_tests();
    integer      fd;
    integer      r;
    integer      c;
    string       tok;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] m;
    logic [31:0] e;
    fd = $fopen("bench/csr_tests.txt", "r");
    if (fd == 0) begin
      abort_run("could not open bench/csr_tests.txt");
    end
    else begin
      while (!$feof(fd)) begin
        r = $fscanf(fd, "%s", tok);
        if (r == 1 && tok == "#") begin
          // skip the rest of a comment line
          c = 0;
          while (c != 10 && c != -1) begin
            c = $fgetc(fd);
          end
        end
        else if (r == 1) begin
          r = $fscanf(fd, "%s %h %h %h %h", op, a, d, m, e);
          if (r != 5) begin
            abort_run("malformed record in bench/csr_tests.txt");
          end
          else begin
            name_q.push_back(tok);
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            mask_q.push_back(m);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_record(input int i);
    logic [31:0] diff;
    if (op_q[i] == "write") begin
      wr.we   = 1'b1;
      wr.addr = addr_q[i][`CSR_ADDR_W-1:0];
      wr.data = data_q[i];
      wr.mask = mask_q[i];
      next_cycle();
      wr.we = 1'b0;
    end
    else if (op_q[i] == "read") begin
      rd_addr = addr_q[i][`CSR_ADDR_W-1:0];
      rdcnt   = `RDCNT_NONE;
      next_cycle();
      check_value(name_q[i], exp_q[i] & mask_q[i], rd_data & mask_q[i]);
      // fetch-side copies carry the same register value
      if (addr_q[i][`CSR_ADDR_W-1:0] == `CSR_ERA) begin
        check_value({name_q[i], ":era_o"}, exp_q[i] & mask_q[i], era & mask_q[i]);
      end
      else if (addr_q[i][`CSR_ADDR_W-1:0] == `CSR_EENTRY) begin
        check_value({name_q[i], ":eentry_o"}, exp_q[i] & mask_q[i], eentry & mask_q[i]);
      end
    end
    else if (op_q[i] == "trap") begin
      // addr holds the flags, mask the fault address
      excp  = addr_q[i][7:0];
      pc    = data_q[i];
      vaddr = mask_q[i];
      next_cycle();
      excp = '0;
    end
    else if (op_q[i] == "ertn") begin
      ertn = 1'b1;
      next_cycle();
      ertn = 1'b0;
    end
    else if (op_q[i] == "idle") begin
      repeat (data_q[i]) next_cycle();
    end
    else if (op_q[i] == "stall") begin
      rd_addr = addr_q[i][`CSR_ADDR_W-1:0];
      stall   = 1'b1;
      repeat (data_q[i]) next_cycle();
      stall = 1'b0;
      check_value(name_q[i], exp_q[i] & mask_q[i], rd_data & mask_q[i]);
    end
    else if (op_q[i] == "rdcnt") begin
      rdcnt = addr_q[i][1:0];
      next_cycle();
      diff     = rd_data - last_cnt;
      last_cnt = rd_data;
      rdcnt    = `RDCNT_NONE;
      check_value(name_q[i], exp_q[i] & mask_q[i], diff & mask_q[i]);
    end
    else if (op_q[i] == "irq") begin
      check_value(name_q[i], exp_q[i] & mask_q[i], {31'b0, int_pending} & mask_q[i]);
    end
    else begin
      abort_run({"unknown operation in test file: ", op_q[i]});
    end
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    wr       = '0;
    rd_addr  = '0;
    rdcnt    = `RDCNT_NONE;
    stall    = 1'b0;
    excp     = '0;
    pc       = '0;
    vaddr    = '0;
    ertn     = 1'b0;
    hw_int   = '0;
    last_cnt = '0;
    loaded   = 1'b0;
    load_tests();
    n_rec  = name_q.size();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_rec; i++) begin
      run_record(i);
    end
    $display("All tests passed!");
    $finish;
  end

  // watchdog scaled to the number of records
  initial begin
    wait (loaded);
    repeat (n_rec * 200) @(posedge clk);
    abort_run("timeout: the tests did not finish within the cycle budget");
  end

endmodule

//--- bench/csr_tests.txt
# name op addr data mask expect, numbers in hex; reads compare under mask
# trap: addr = exception flags, data = pc, mask = vaddr; idle and stall: data = cycles
save0_init    write 030 ffffffff ffffffff 0
save0_masked  write 030 12345678 0000ffff 0
save0_read    read  030 0 ffffffff ffff5678
crmd_masked   write 000 fffffe05 fffffe07 0
crmd_read     read  000 0 ffffffff 0000000d
sys_trap      trap  08 1c000100 0 0
sys_ecode     read  005 0 7fff0000 000b0000
sys_era       read  006 0 ffffffff 1c000100
sys_prmd      read  001 0 00000007 00000005
sys_crmd      read  000 0 ffffffff 00000008
sys_ertn      ertn  0 0 0 0
ertn_crmd     read  000 0 ffffffff 0000000d
ale_trap      trap  10 1c000200 00001233 0
ale_ecode     read  005 0 7fff0000 00090000
ale_badv      read  007 0 ffffffff 00001233
ale_ertn      ertn  0 0 0 0
tcfg_oneshot  write 041 00000015 ffffffff 0
timer_wait    idle  0 28 0 0
timer_irq     read  005 0 00000800 00000800
timer_tval    read  042 0 ffffffff ffffffff
ticlr_write   write 044 00000001 00000001 0
ticlr_irq     read  005 0 00000800 00000000
ectl_enable   write 004 00000001 ffffffff 0
swi_set       write 005 00000001 00000003 0
irq_high      irq   0 0 00000001 00000001
ectl_clear    write 004 00000000 ffffffff 0
irq_low       irq   0 0 00000001 00000000
save1_write   write 031 000000aa ffffffff 0
save1_read    read  031 0 ffffffff 000000aa
stall_hold    stall 000 4 ffffffff 000000aa
vlow_first    rdcnt 2 0 00000000 0
vlow_gap      idle  0 3 0 0
vlow_second   rdcnt 2 0 ffffffff 00000004

//--- common/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_ADDR_W 14
`define CSR_DATA_W 32

// csr addresses
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECTL   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_BADV   14'h007
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

// field positions
`define TCFG_EN        0
`define TCFG_PERIODIC  1
`define TCFG_INITVAL   31:2
`define TICLR_CLR      0
`define ECTL_LIE_MASK  32'h0000_1bff
`define EENTRY_VA_MASK 32'hffff_ffc0
`define TIMER_IRQ_BIT  11
`define HW_IRQ_W       8

// exception codes
`define ECODE_INT 6'h00
`define ECODE_ADE 6'h08
`define ECODE_ALE 6'h09
`define ECODE_SYS 6'h0b
`define ECODE_BRK 6'h0c
`define ECODE_INE 6'h0d
`define ECODE_IPE 6'h0e

`define ESUBCODE_ADEM 9'd1

// rdcnt selectors
`define RDCNT_NONE  2'd0
`define RDCNT_ID    2'd1
`define RDCNT_VLOW  2'd2
`define RDCNT_VHIGH 2'd3

`endif

//--- common/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

  typedef struct packed {
    logic                   we;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_DATA_W-1:0] mask;
    logic [`CSR_DATA_W-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic [22:0] rsvd;
    logic [1:0]  datm;
    logic [1:0]  datf;
    logic        pg;
    logic        da;
    logic        ie;
    logic [1:0]  plv;
  } crmd_t;

  typedef struct packed {
    logic [28:0] rsvd;
    logic        pie;
    logic [1:0]  pplv;
  } prmd_t;

  typedef struct packed {
    logic        rsvd_hi;
    logic [8:0]  esubcode;
    logic [5:0]  ecode;
    logic [2:0]  rsvd_lo;
    logic [12:0] is;
  } estat_t;

  // highest priority first
  typedef struct packed {
    logic intr;
    logic adef;
    logic adem;
    logic ale;
    logic sys;
    logic brk;
    logic ine;
    logic ipe;
  } excp_t;

  typedef struct packed {
    logic                   valid;
    logic [5:0]             ecode;
    logic [8:0]             esubcode;
    logic                   badv_we;
    logic [`CSR_DATA_W-1:0] badv;
  } trap_t;

  typedef struct packed {
    crmd_t                  crmd;
    prmd_t                  prmd;
    logic [`CSR_DATA_W-1:0] ectl;
    estat_t                 estat;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] eentry;
    logic [`CSR_DATA_W-1:0] save0;
    logic [`CSR_DATA_W-1:0] save1;
    logic [`CSR_DATA_W-1:0] save2;
    logic [`CSR_DATA_W-1:0] save3;
    logic [`CSR_DATA_W-1:0] tid;
  } csr_view_t;

  typedef struct packed {
    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] tval;
    logic [`CSR_DATA_W-1:0] ticlr;
  } timer_view_t;

  // old bits outside the mask, new bits inside
  function automatic logic [`CSR_DATA_W-1:0] wr_merge(input logic [`CSR_DATA_W-1:0] cur,
                                                      input csr_wr_t wr);
    return (cur & ~wr.mask) | (wr.data & wr.mask);
  endfunction

endpackage

//--- csr/csr_read_mux.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_read_mux (
  input  logic                   clk,
  input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
  input  logic [1:0]             rdcnt_i,
  input  logic                   stall_i,
  input  csr_pkg::csr_view_t     csr_view_i,
  input  csr_pkg::timer_view_t   timer_view_i,
  input  logic [63:0]            stable_cnt_i,
  output logic [`CSR_DATA_W-1:0] rd_data_o
);

  logic [`CSR_DATA_W-1:0] rd_sel;

  always_comb begin
    rd_sel = '0;
    if (rdcnt_i == `RDCNT_NONE) begin
      case (rd_addr_i)
        `CSR_CRMD:   rd_sel = csr_view_i.crmd;
        `CSR_PRMD:   rd_sel = csr_view_i.prmd;
        `CSR_ECTL:   rd_sel = csr_view_i.ectl;
        `CSR_ESTAT:  rd_sel = csr_view_i.estat;
        `CSR_ERA:    rd_sel = csr_view_i.era;
        `CSR_BADV:   rd_sel = csr_view_i.badv;
        `CSR_EENTRY: rd_sel = csr_view_i.eentry;
        `CSR_SAVE0:  rd_sel = csr_view_i.save0;
        `CSR_SAVE1:  rd_sel = csr_view_i.save1;
        `CSR_SAVE2:  rd_sel = csr_view_i.save2;
        `CSR_SAVE3:  rd_sel = csr_view_i.save3;
        `CSR_TID:    rd_sel = csr_view_i.tid;
        `CSR_TCFG:   rd_sel = timer_view_i.tcfg;
        `CSR_TVAL:   rd_sel = timer_view_i.tval;
        `CSR_TICLR:  rd_sel = timer_view_i.ticlr;
        default:     rd_sel = '0;
      endcase
    end
    else if (rdcnt_i == `RDCNT_ID) begin
      rd_sel = csr_view_i.tid;
    end
    else if (rdcnt_i == `RDCNT_VLOW) begin
      rd_sel = stable_cnt_i[31:0];
    end
    else if (rdcnt_i == `RDCNT_VHIGH) begin
      rd_sel = stable_cnt_i[63:32];
    end
  end

  // hold the last word during a stall
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      rd_data_o <= rd_sel;
    end
  end

endmodule

//--- csr/csr_regs.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  csr_pkg::csr_wr_t       wr_i,
  input  logic                   stall_i,
  input  csr_pkg::trap_t         trap_i,
  input  logic [`CSR_DATA_W-1:0] pc_i,
  input  logic                   ertn_i,
  input  logic [`HW_IRQ_W-1:0]   hw_int_i,
  input  logic                   timer_fire_i,
  input  logic                   ti_clr_i,
  output csr_pkg::csr_view_t     view_o,
  output logic                   int_pending_o
);

  import csr_pkg::*;

  crmd_t                  crmd_q;
  crmd_t                  crmd_wr;
  prmd_t                  prmd_q;
  prmd_t                  prmd_wr;
  estat_t                 estat_q;
  estat_t                 estat_wr;
  logic [`CSR_DATA_W-1:0] ectl_q;
  logic [`CSR_DATA_W-1:0] era_q;
  logic [`CSR_DATA_W-1:0] badv_q;
  logic [`CSR_DATA_W-1:0] eentry_q;
  logic [`CSR_DATA_W-1:0] save0_q;
  logic [`CSR_DATA_W-1:0] save1_q;
  logic [`CSR_DATA_W-1:0] save2_q;
  logic [`CSR_DATA_W-1:0] save3_q;
  logic [`CSR_DATA_W-1:0] tid_q;
  logic                   wr_en;

  assign wr_en    = wr_i.we && !stall_i;
  assign crmd_wr  = wr_merge(crmd_q, wr_i);
  assign prmd_wr  = wr_merge(prmd_q, wr_i);
  assign estat_wr = wr_merge(estat_q, wr_i);

  // control registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q    <= '0;
      crmd_q.da <= 1'b1;
      prmd_q    <= '0;
      ectl_q    <= '0;
      estat_q   <= '0;
    end
    else begin
      estat_q.is[9:2] <= hw_int_i;
      // clear beats a fire in the same cycle
      if (ti_clr_i) begin
        estat_q.is[`TIMER_IRQ_BIT] <= 1'b0;
      end
      else if (timer_fire_i) begin
        estat_q.is[`TIMER_IRQ_BIT] <= 1'b1;
      end

      if (trap_i.valid) begin
        prmd_q.pplv      <= crmd_q.plv;
        prmd_q.pie       <= crmd_q.ie;
        crmd_q.plv       <= 2'd0;
        crmd_q.ie        <= 1'b0;
        estat_q.ecode    <= trap_i.ecode;
        estat_q.esubcode <= trap_i.esubcode;
      end
      else if (ertn_i) begin
        crmd_q.plv <= prmd_q.pplv;
        crmd_q.ie  <= prmd_q.pie;
      end

      if (wr_en) begin
        case (wr_i.addr)
          `CSR_CRMD: begin
            crmd_q.plv  <= crmd_wr.plv;
            crmd_q.ie   <= crmd_wr.ie;
            crmd_q.da   <= crmd_wr.da;
            crmd_q.pg   <= crmd_wr.pg;
            crmd_q.datf <= crmd_wr.datf;
            crmd_q.datm <= crmd_wr.datm;
          end
          `CSR_PRMD: begin
            prmd_q.pplv <= prmd_wr.pplv;
            prmd_q.pie  <= prmd_wr.pie;
          end
          `CSR_ECTL:  ectl_q <= wr_merge(ectl_q, wr_i) & `ECTL_LIE_MASK;
          // only the software interrupt bits
          `CSR_ESTAT: estat_q.is[1:0] <= estat_wr.is[1:0];
          default: ;
        endcase
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (trap_i.valid) begin
      era_q <= pc_i;
      if (trap_i.badv_we) begin
        badv_q <= trap_i.badv;
      end
    end
    if (wr_en) begin
      case (wr_i.addr)
        `CSR_ERA:    era_q    <= wr_merge(era_q, wr_i);
        `CSR_BADV:   badv_q   <= wr_merge(badv_q, wr_i);
        `CSR_EENTRY: eentry_q <= wr_merge(eentry_q, wr_i) & `EENTRY_VA_MASK;
        `CSR_SAVE0:  save0_q  <= wr_merge(save0_q, wr_i);
        `CSR_SAVE1:  save1_q  <= wr_merge(save1_q, wr_i);
        `CSR_SAVE2:  save2_q  <= wr_merge(save2_q, wr_i);
        `CSR_SAVE3:  save3_q  <= wr_merge(save3_q, wr_i);
        `CSR_TID:    tid_q    <= wr_merge(tid_q, wr_i);
        default: ;
      endcase
    end
  end

  assign int_pending_o = crmd_q.ie && ((estat_q.is & ectl_q[12:0]) != '0);

  assign view_o.crmd   = crmd_q;
  assign view_o.prmd   = prmd_q;
  assign view_o.ectl   = ectl_q;
  assign view_o.estat  = estat_q;
  assign view_o.era    = era_q;
  assign view_o.badv   = badv_q;
  assign view_o.eentry = eentry_q;
  assign view_o.save0  = save0_q;
  assign view_o.save1  = save1_q;
  assign view_o.save2  = save2_q;
  assign view_o.save3  = save3_q;
  assign view_o.tid    = tid_q;

endmodule

//--- csr/trap_unit.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module trap_unit (
  input  csr_pkg::excp_t         excp_i,
  input  logic [`CSR_DATA_W-1:0] pc_i,
  input  logic [`CSR_DATA_W-1:0] vaddr_i,
  output csr_pkg::trap_t         trap_o
);

  always_comb begin
    trap_o       = '0;
    trap_o.valid = |excp_i;
    trap_o.badv  = vaddr_i;
    if (excp_i.intr) begin
      trap_o.ecode = `ECODE_INT;
    end
    else if (excp_i.adef) begin
      // fetch fault, bad address is the pc itself
      trap_o.ecode   = `ECODE_ADE;
      trap_o.badv_we = 1'b1;
      trap_o.badv    = pc_i;
    end
    else if (excp_i.adem) begin
      trap_o.ecode    = `ECODE_ADE;
      trap_o.esubcode = `ESUBCODE_ADEM;
      trap_o.badv_we  = 1'b1;
    end
    else if (excp_i.ale) begin
      trap_o.ecode   = `ECODE_ALE;
      trap_o.badv_we = 1'b1;
    end
    else if (excp_i.sys) begin
      trap_o.ecode = `ECODE_SYS;
    end
    else if (excp_i.brk) begin
      trap_o.ecode = `ECODE_BRK;
    end
    else if (excp_i.ine) begin
      trap_o.ecode = `ECODE_INE;
    end
    else if (excp_i.ipe) begin
      trap_o.ecode = `ECODE_IPE;
    end
  end

endmodule

//--- files.f
+incdir+common
common/csr_pkg.sv
csr/trap_unit.sv
csr/csr_regs.sv
csr/csr_read_mux.sv
timer/csr_timer.sv
logic/csr_top.sv
bench/csr_assertions.sv
bench/csr_tb.sv

//--- logic/csr_top.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  csr_pkg::csr_wr_t       wr_i,
  input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
  input  logic [1:0]             rdcnt_i,
  input  logic                   stall_i,
  input  csr_pkg::excp_t         excp_i,
  input  logic [`CSR_DATA_W-1:0] pc_i,
  input  logic [`CSR_DATA_W-1:0] vaddr_i,
  input  logic                   ertn_i,
  input  logic [`HW_IRQ_W-1:0]   hw_int_i,
  output logic [`CSR_DATA_W-1:0] rd_data_o,
  output logic                   int_pending_o,
  output logic [`CSR_DATA_W-1:0] era_o,
  output logic [`CSR_DATA_W-1:0] eentry_o
);

  import csr_pkg::*;

  trap_t       trap;
  csr_view_t   csr_view;
  timer_view_t timer_view;
  logic        timer_fire;
  logic        ti_clr;
  logic [63:0] stable_cnt;

  trap_unit u_trap (
    .excp_i  (excp_i),
    .pc_i    (pc_i),
    .vaddr_i (vaddr_i),
    .trap_o  (trap)
  );

  csr_regs u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_i          (wr_i),
    .stall_i       (stall_i),
    .trap_i        (trap),
    .pc_i          (pc_i),
    .ertn_i        (ertn_i),
    .hw_int_i      (hw_int_i),
    .timer_fire_i  (timer_fire),
    .ti_clr_i      (ti_clr),
    .view_o        (csr_view),
    .int_pending_o (int_pending_o)
  );

  csr_timer u_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (wr_i),
    .stall_i      (stall_i),
    .timer_fire_o (timer_fire),
    .ti_clr_o     (ti_clr),
    .view_o       (timer_view),
    .stable_cnt_o (stable_cnt)
  );

  csr_read_mux u_rd (
    .clk          (clk),
    .rd_addr_i    (rd_addr_i),
    .rdcnt_i      (rdcnt_i),
    .stall_i      (stall_i),
    .csr_view_i   (csr_view),
    .timer_view_i (timer_view),
    .stable_cnt_i (stable_cnt),
    .rd_data_o    (rd_data_o)
  );

  // exception return and entry targets for the fetch stage
  assign era_o    = csr_view.era;
  assign eentry_o = csr_view.eentry;

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module csr_tb -o csr_sim
./obj_dir/csr_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- timer/csr_timer.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_timer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_wr_t     wr_i,
  input  logic                 stall_i,
  output logic                 timer_fire_o,
  output logic                 ti_clr_o,
  output csr_pkg::timer_view_t view_o,
  output logic [63:0]          stable_cnt_o
);

  import csr_pkg::*;

  typedef enum logic [1:0] {
    T_OFF,
    T_COUNT,
    T_WRAP
  } tstate_e;

  tstate_e                state_q;
  tstate_e                state_d;
  logic [`CSR_DATA_W-1:0] tcfg_q;
  logic [`CSR_DATA_W-1:0] tcfg_wr;
  logic [`CSR_DATA_W-1:0] tval_q;
  logic [`CSR_DATA_W-1:0] tval_d;
  logic [`CSR_DATA_W-1:0] ticlr_wr;
  logic [63:0]            stable_q;
  logic                   tcfg_we;
  logic                   ticlr_we;
  logic                   run;

  assign tcfg_we  = wr_i.we && !stall_i && (wr_i.addr == `CSR_TCFG);
  assign ticlr_we = wr_i.we && !stall_i && (wr_i.addr == `CSR_TICLR);
  assign tcfg_wr  = wr_merge(tcfg_q, wr_i);
  assign ticlr_wr = wr_i.data & wr_i.mask;

  // wrap step keeps counting only in periodic mode
  assign run = (state_q == T_COUNT) || (state_q == T_WRAP && tcfg_q[`TCFG_PERIODIC]);

  always_comb begin
    state_d = state_q;
    tval_d  = tval_q;
    if (tcfg_we) begin
      tval_d  = {tcfg_wr[`TCFG_INITVAL], 2'b00};
      state_d = tcfg_wr[`TCFG_EN] ? T_COUNT : T_OFF;
    end
    else if (run) begin
      if (tval_q != '0) begin
        tval_d  = tval_q - 1'b1;
        state_d = T_COUNT;
      end
      else begin
        tval_d  = tcfg_q[`TCFG_PERIODIC] ? {tcfg_q[`TCFG_INITVAL], 2'b00} : '1;
        state_d = T_WRAP;
      end
    end
    else if (state_q == T_WRAP) begin
      state_d = T_OFF;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= T_OFF;
      tcfg_q  <= '0;
      tval_q  <= '0;
    end
    else begin
      state_q <= state_d;
      tval_q  <= tval_d;
      if (tcfg_we) begin
        tcfg_q <= tcfg_wr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stable_q <= '0;
    end
    else begin
      stable_q <= stable_q + 64'd1;
    end
  end

  assign timer_fire_o = (state_q == T_WRAP);
  assign ti_clr_o     = ticlr_we && ticlr_wr[`TICLR_CLR];
  assign stable_cnt_o = stable_q;

  assign view_o.tcfg  = tcfg_q;
  assign view_o.tval  = tval_q;
  // write-only, reads as zero
  assign view_o.ticlr = '0;

endmodule
